// ==== hdl/quarkPkg.sv ====
/*
 * Quark RV32I core shared definitions
 * Word width, opcode classes, FSM states and funct3 codes
 */
package quarkPkg;

   // Data and instruction word width
   localparam int xlen = 32;
   // Architectural registers x0..x31
   localparam int regCount = 32;

   // Major opcodes, instr[6:2]
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opJal    = 5'b11011;

   // One-hot FSM states
   typedef enum logic [3:0] {
      fetchInstr   = 4'b0001,
      waitInstr    = 4'b0010,
      execute      = 4'b0100,
      waitAluOrMem = 4'b1000
   } stateT;

   // Access size, funct3[1:0] of loads and stores
   localparam logic [1:0] sizeByte = 2'b00;
   localparam logic [1:0] sizeHalf = 2'b01;
   localparam logic [1:0] sizeWord = 2'b10;

   // ALU functions as bit positions in the one-hot funct3
   localparam int aluAdd  = 0;
   localparam int aluSll  = 1;
   localparam int aluSlt  = 2;
   localparam int aluSltu = 3;
   localparam int aluXor  = 4;
   localparam int aluSr   = 5;
   localparam int aluOr   = 6;
   localparam int aluAnd  = 7;

   // Branch conditions, same one-hot positions
   localparam int brEq  = 0;
   localparam int brNe  = 1;
   localparam int brLt  = 4;
   localparam int brGe  = 5;
   localparam int brLtu = 6;
   localparam int brGeu = 7;

endpackage

// ==== hdl/quarkDecoder.sv ====
/*
 * Quark instruction decoder
 * Class flags, one-hot funct3, destination index and immediates
 */
`timescale 1ns/1ps

module quarkDecoder import quarkPkg::*; (
   input  logic [31:2]                 instr,
   output logic                        isLoad,
   output logic                        isAluImm,
   output logic                        isAuipc,
   output logic                        isStore,
   output logic                        isAluReg,
   output logic                        isLui,
   output logic                        isBranch,
   output logic                        isJalr,
   output logic                        isJal,
   output logic [7:0]                  funct3Is,
   output logic [$clog2(regCount)-1:0] rdId,
   output logic [xlen-1:0]             immI,
   output logic [xlen-1:0]             immS,
   output logic [xlen-1:0]             immB,
   output logic [xlen-1:0]             immU,
   output logic [xlen-1:0]             immJ
);

   logic [4:0] opcode;

   // Bits 1:0 are always 11 in RV32I and never stored
   assign opcode = instr[6:2];

   // Exactly one class flag per valid opcode
   assign isLoad   = (opcode == opLoad);
   assign isAluImm = (opcode == opAluImm);
   assign isAuipc  = (opcode == opAuipc);
   assign isStore  = (opcode == opStore);
   assign isAluReg = (opcode == opAluReg);
   assign isLui    = (opcode == opLui);
   assign isBranch = (opcode == opBranch);
   assign isJalr   = (opcode == opJalr);
   assign isJal    = (opcode == opJal);

   // funct3Is[n] is high when funct3 equals n
   assign funct3Is = 8'b0000_0001 << instr[14:12];

   assign rdId = instr[11:7];

   // Immediate formats, all sign extended from bit 31
   assign immI = {{21{instr[31]}}, instr[30:20]};
   assign immS = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   // B and J carry an implicit zero at bit 0
   assign immB = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign immJ = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
   // Upper immediate fills the low 12 bits with zero
   assign immU = {instr[31:12], 12'b0};

endmodule

// ==== hdl/quarkRegFile.sv ====
/*
 * Quark register file
 * 32 x 32 registers, both reads registered on the latch strobe
 */
`timescale 1ns/1ps

module quarkRegFile import quarkPkg::*; (
   input  logic                        clk,
   input  logic                        resetn,
   input  logic                        latch,
   input  logic [xlen-1:0]             memRdata,
   input  logic                        writeBack,
   input  logic [$clog2(regCount)-1:0] rdId,
   input  logic [xlen-1:0]             writeBackData,
   output logic [xlen-1:0]             rs1,
   output logic [xlen-1:0]             rs2
);

   logic [xlen-1:0] regs [regCount];

   always_ff @(posedge clk) begin
      if (!resetn) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeBack && rdId != '0) begin
         // x0 is hardwired zero
         regs[rdId] <= writeBackData;
      end
   end

   // Source indices come straight from the incoming instruction word
   always_ff @(posedge clk) begin
      if (latch) begin
         rs1 <= regs[memRdata[19:15]];
         rs2 <= regs[memRdata[24:20]];
      end
   end

   // x0 must read zero whatever the core writes back
   assert property (@(posedge clk) disable iff (!resetn) regs[0] == '0)
      else $error("x0 was written with %h", regs[0]);

endmodule

// ==== hdl/quarkAlu.sv ====
/*
 * Quark ALU
 * Shared adder, 33-bit compare, reversible shifter and branch predicate
 */
`timescale 1ns/1ps

module quarkAlu import quarkPkg::*; (
   input  logic [xlen-1:0] rs1,
   input  logic [xlen-1:0] rs2,
   input  logic [xlen-1:0] pc,
   input  logic [31:2]     instr,
   input  logic            isLoad,
   input  logic            isAluImm,
   input  logic            isAuipc,
   input  logic            isStore,
   input  logic            isAluReg,
   input  logic            isBranch,
   input  logic            isJalr,
   input  logic            isJal,
   input  logic [7:0]      funct3Is,
   input  logic [xlen-1:0] immI,
   input  logic [xlen-1:0] immS,
   input  logic [xlen-1:0] immB,
   input  logic [xlen-1:0] immU,
   input  logic [xlen-1:0] immJ,
   output logic [xlen-1:0] aluPlus,
   output logic [xlen-1:0] aluOut,
   output logic            predicate
);

   logic [xlen-1:0] aluIn2;
   logic [xlen-1:0] plusIn1;
   logic [xlen-1:0] plusIn2;
   logic [xlen:0]   aluMinus;
   logic            lt;
   logic            ltu;
   logic            eq;
   logic [xlen-1:0] shiftSrc;
   logic [xlen:0]   shiftOut;
   logic [xlen-1:0] leftShift;
   logic            isSub;

   function automatic logic [xlen-1:0] reverseBits(input logic [xlen-1:0] v);
      logic [xlen-1:0] r;
      for (int i = 0; i < xlen; i++) begin
         r[i] = v[xlen-1-i];
      end
      return r;
   endfunction

   // Register-register ops and branches compare against rs2
   assign aluIn2 = (isAluReg | isBranch) ? rs2 : immI;

   // One adder for ALU ops, load/store addresses and jump targets
   assign plusIn1 = (isAluImm | isAluReg | isStore | isLoad | isJalr) ? rs1 : pc;
   assign plusIn2 = isStore  ? immS :
                    isJal    ? immJ :
                    isAuipc  ? immU :
                    isBranch ? immB :
                    isAluReg ? rs2  : immI;
   assign aluPlus = plusIn1 + plusIn2;

   // Borrow out gives unsigned less-than
   assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
   assign ltu      = aluMinus[xlen];
   // Signs differ so rs1 negative means less
   assign lt       = (rs1[xlen-1] ^ aluIn2[xlen-1]) ? rs1[xlen-1] : aluMinus[xlen];
   assign eq       = (aluMinus[xlen-1:0] == '0);

   // Left shift runs through the right shifter on reversed bits
   assign shiftSrc  = funct3Is[aluSll] ? reverseBits(rs1) : rs1;
   // instr[30] selects arithmetic right shift
   assign shiftOut  = $signed({instr[30] & rs1[xlen-1], shiftSrc}) >>> aluIn2[4:0];
   assign leftShift = reverseBits(shiftOut[xlen-1:0]);

   // SUB needs instr[5] too, ADDI reuses bit 30 as immediate
   assign isSub = instr[30] & instr[5];

   always_comb begin
      aluOut = '0;
      unique case (1'b1)
         funct3Is[aluAdd]:  aluOut = isSub ? aluMinus[xlen-1:0] : aluPlus;
         funct3Is[aluSll]:  aluOut = leftShift;
         funct3Is[aluSlt]:  aluOut = {{(xlen-1){1'b0}}, lt};
         funct3Is[aluSltu]: aluOut = {{(xlen-1){1'b0}}, ltu};
         funct3Is[aluXor]:  aluOut = rs1 ^ aluIn2;
         funct3Is[aluSr]:   aluOut = shiftOut[xlen-1:0];
         funct3Is[aluOr]:   aluOut = rs1 | aluIn2;
         default:           aluOut = rs1 & aluIn2;
      endcase
   end

   // Codes 2 and 3 are not branches and never match
   assign predicate = (funct3Is[brEq]  &  eq)  |
                      (funct3Is[brNe]  & ~eq)  |
                      (funct3Is[brLt]  &  lt)  |
                      (funct3Is[brGe]  & ~lt)  |
                      (funct3Is[brLtu] &  ltu) |
                      (funct3Is[brGeu] & ~ltu);

endmodule

// ==== hdl/quarkLoadStore.sv ====
/*
 * Quark load/store alignment
 * Store lane replication and mask, load extraction with extension
 */
`timescale 1ns/1ps

module quarkLoadStore import quarkPkg::*; (
   input  logic [31:2]     instr,
   input  logic [xlen-1:0] aluPlus,
   input  logic [xlen-1:0] rs2,
   input  logic [xlen-1:0] memRdata,
   output logic [xlen-1:0] memWdata,
   output logic [3:0]      lsMask,
   output logic [xlen-1:0] loadData
);

   logic [1:0]  size;
   logic [1:0]  offset;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // funct3[1:0] gives the size, the adder gives the byte offset
   assign size   = instr[13:12];
   assign offset = aluPlus[1:0];

   // Store data replicated so every lane holds the right byte
   assign memWdata[7:0]   = rs2[7:0];
   assign memWdata[15:8]  = offset[0] ? rs2[7:0] : rs2[15:8];
   assign memWdata[23:16] = offset[1] ? rs2[7:0] : rs2[23:16];
   assign memWdata[31:24] = offset[0] ? rs2[7:0] :
                            offset[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      unique case (size)
         // One lane per byte offset
         sizeByte: lsMask = 4'b0001 << offset;
         // Lower or upper pair
         sizeHalf: lsMask = offset[1] ? 4'b1100 : 4'b0011;
         sizeWord: lsMask = 4'b1111;
         default:  lsMask = 4'b1111;
      endcase
   end

   // Addressed halfword, then byte inside it
   assign loadHalf = offset[1] ? memRdata[31:16] : memRdata[15:0];
   assign loadByte = offset[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set means zero extension
   assign loadSign = ~instr[14] & ((size == sizeByte) ? loadByte[7] : loadHalf[15]);

   always_comb begin
      unique case (size)
         sizeByte: loadData = {{24{loadSign}}, loadByte};
         sizeHalf: loadData = {{16{loadSign}}, loadHalf};
         default:  loadData = memRdata;
      endcase
   end

endmodule

// ==== hdl/quarkControl.sv ====
/*
 * Quark control
 * One-hot FSM, program counter, instruction latch, bus strobes, write-back
 */
`timescale 1ns/1ps

module quarkControl import quarkPkg::*; #(
   parameter logic [xlen-1:0] resetAddr = '0,
   parameter int              addrWidth = 32
) (
   input  logic            clk,
   input  logic            resetn,
   input  logic [xlen-1:0] memRdata,
   input  logic            memRbusy,
   input  logic            memWbusy,
   input  logic            isLoad,
   input  logic            isAluImm,
   input  logic            isAuipc,
   input  logic            isStore,
   input  logic            isAluReg,
   input  logic            isLui,
   input  logic            isBranch,
   input  logic            isJalr,
   input  logic            isJal,
   input  logic [xlen-1:0] aluPlus,
   input  logic [xlen-1:0] aluOut,
   input  logic            predicate,
   input  logic [xlen-1:0] immU,
   input  logic [xlen-1:0] loadData,
   input  logic [3:0]      lsMask,
   output logic [31:2]     instr,
   output logic [xlen-1:0] pc,
   output logic            latch,
   output logic            writeBack,
   output logic [xlen-1:0] writeBackData,
   output logic [xlen-1:0] memAddr,
   output logic [3:0]      memMask,
   output logic            memRstrb,
   output logic            memWstrb
);

   stateT                state;
   logic [addrWidth-1:0] pcReg;
   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcNext;
   logic [addrWidth-1:0] addrSel;
   logic                 isMem;
   logic                 jump;
   logic                 memPhase;

   assign isMem    = isLoad | isStore;
   assign memPhase = (state == execute) | (state == waitAluOrMem);
   assign pc       = xlen'(pcReg);

   // Jumps and taken branches use the adder, bit 0 cleared for JALR
   assign jump    = isJal | isJalr | (isBranch & predicate);
   assign pcPlus4 = pcReg + addrWidth'(4);
   assign pcNext  = jump ? {aluPlus[addrWidth-1:1], 1'b0} : pcPlus4;

   // Fetch at PC, prefetch at next PC from execute, else data address
   assign addrSel = (state == fetchInstr || state == waitInstr) ? pcReg :
                    (state == execute && !isMem)                 ? pcNext :
                                                                   aluPlus[addrWidth-1:0];
   assign memAddr = xlen'(addrSel);

   // Read strobe also serves the prefetch and the load
   assign memRstrb = (state == fetchInstr) | ((state == execute) & ~isStore);
   assign memWstrb = (state == execute) & isStore;
   assign memMask  = (memPhase & isMem) ? lsMask : 4'b1111;

   // Instruction and source registers are captured on the same edge
   assign latch     = (state == waitInstr) & ~memRbusy;
   assign writeBack = ~(isBranch | isStore) & memPhase;

   // Classes are exclusive, so an OR of gated values is enough
   assign writeBackData = ({xlen{isLui}}              & immU)          |
                          ({xlen{isAluImm | isAluReg}} & aluOut)       |
                          ({xlen{isAuipc}}            & aluPlus)       |
                          ({xlen{isJal | isJalr}}      & xlen'(pcPlus4)) |
                          ({xlen{isLoad}}             & loadData);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         // Wait for the bus to go idle before the first fetch
         state <= waitAluOrMem;
         pcReg <= resetAddr[addrWidth-1:0];
         // ADDI x0, x0, 0 so the write-back in the wait state is harmless
         instr <= {25'd0, opAluImm};
      end else begin
         unique case (state)
            waitInstr: begin
               if (!memRbusy) begin
                  instr <= memRdata[31:2];
                  state <= execute;
               end
            end
            execute: begin
               pcReg <= pcNext;
               state <= isMem ? waitAluOrMem : waitInstr;
            end
            waitAluOrMem: begin
               if (!memRbusy && !memWbusy) state <= fetchInstr;
            end
            default: state <= waitInstr;
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!resetn) $onehot(state))
      else $error("state not one-hot: %b", state);
   assert property (@(posedge clk) disable iff (!resetn) !(memRstrb && memWstrb))
      else $error("read and write strobes together");

endmodule

// ==== hdl/quarkCore.sv ====
/*
 * Quark multi-cycle RV32I core
 * Connects control, decoder, register file, ALU and load/store
 */
`timescale 1ns/1ps

module quarkCore import quarkPkg::*; #(
   parameter logic [xlen-1:0] resetAddr = '0,
   parameter int              addrWidth = 32
) (
   input  logic            clk,
   input  logic            resetn,
   output logic [xlen-1:0] memAddr,
   output logic [xlen-1:0] memWdata,
   output logic [3:0]      memMask,
   output logic            memRstrb,
   output logic            memWstrb,
   input  logic [xlen-1:0] memRdata,
   input  logic            memRbusy,
   input  logic            memWbusy
);

   logic [31:2]                 instr;
   logic [xlen-1:0]             pc, rs1, rs2, aluPlus, aluOut, loadData, writeBackData;
   logic [xlen-1:0]             immI, immS, immB, immU, immJ;
   logic [7:0]                  funct3Is;
   logic [$clog2(regCount)-1:0] rdId;
   logic [3:0]                  lsMask;
   logic                        isLoad, isAluImm, isAuipc, isStore, isAluReg;
   logic                        isLui, isBranch, isJalr, isJal;
   logic                        predicate, latch, writeBack;

   quarkControl #(.resetAddr(resetAddr), .addrWidth(addrWidth)) control (.*);

   quarkDecoder decoder (.*);

   // Source indices are taken from the incoming word, not the latched one
   quarkRegFile regFile (.*);

   quarkAlu alu (.*);

   // Effective address comes from the shared adder
   quarkLoadStore loadStore (.*);

endmodule

// ==== testbench/quarkMemModel.sv ====
/*
 * Word memory for the Quark testbench
 * Random 0 to 3 cycle busy after each strobe, test program preloaded
 */
`timescale 1ns/1ps

module quarkMemModel import quarkPkg::*; #(
   parameter logic [31:0] bootAddr      = 32'h100,
   parameter logic [31:0] auipcAt       = 32'h400,
   parameter logic [31:0] jalAt         = 32'h600,
   parameter logic [31:0] jalrAt        = 32'h680,
   parameter logic [31:0] dataAddr      = 32'h700,
   parameter logic [31:0] resultAddr    = 32'h1000,
   parameter logic [31:0] markerData    = 32'h123,
   parameter logic [31:0] wrongPathData = 32'h7BD
) (
   input  logic        clk,
   input  logic        resetn,
   input  logic [31:0] memAddr,
   input  logic [31:0] memWdata,
   input  logic [3:0]  memMask,
   input  logic        memRstrb,
   input  logic        memWstrb,
   output logic [31:0] memRdata,
   output logic        memRbusy,
   output logic        memWbusy
);

   // 8 KB, enough for code, data word and results
   logic [31:0] mem [2048];
   logic [31:0] ptr;
   logic [10:0] rdWord;
   int          pending;
   int          delay;
   integer      seed;

   function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
      return {f7, rs2, rs1, f3, rd, opAluReg, 2'b11};
   endfunction

   function automatic logic [31:0] iType(input logic [4:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [31:0] imm);
      return {imm[11:0], rs1, f3, rd, op, 2'b11};
   endfunction

   // Store always uses x31 as the base
   function automatic logic [31:0] sType(input logic [2:0] f3, input logic [4:0] rs2,
                                         input logic [31:0] imm);
      return {imm[11:5], rs2, 5'd31, f3, imm[4:0], opStore, 2'b11};
   endfunction

   function automatic logic [31:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [31:0] imm);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch, 2'b11};
   endfunction

   function automatic logic [31:0] uType(input logic [4:0] op, input logic [4:0] rd,
                                         input logic [19:0] imm);
      return {imm, rd, op, 2'b11};
   endfunction

   function automatic logic [31:0] jType(input logic [4:0] rd, input logic [31:0] imm);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal, 2'b11};
   endfunction

   task automatic emit(input logic [31:0] word);
      mem[ptr[12:2]] = word;
      ptr = ptr + 4;
   endtask

   // Jump ahead to a fixed address and continue building there
   task automatic org(input logic [31:0] addr);
      emit(jType(5'd0, addr - ptr));
      ptr = addr;
   endtask

   // Result word slot n lives at x31 + 4n
   task automatic storeSlot(input logic [4:0] rs, input int slot);
      emit(sType(3'b010, rs, 32'(slot * 4)));
   endtask

   task automatic aluTest(input logic [6:0] f7, input logic [2:0] f3, input int slot);
      emit(rType(f7, f3, 5'd3, 5'd1, 5'd2));
      storeSlot(5'd3, slot);
   endtask

   // Loaded value from x5 + off goes back out as a word
   task automatic loadTest(input logic [2:0] f3, input int off, input int slot);
      emit(iType(opLoad, f3, 5'd6, 5'd5, 32'(off)));
      storeSlot(5'd6, slot);
   endtask

   // Wrong path stores x8, correct path stores the marker in x7
   task automatic branchTest(input logic [2:0] f3, input logic [4:0] ra,
                             input logic [4:0] rb, input bit taken, input int slot);
      if (taken) begin
         emit(bType(f3, ra, rb, 32'd8));
         storeSlot(5'd8, slot);
         storeSlot(5'd7, slot);
      end else begin
         emit(bType(f3, ra, rb, 32'd12));
         storeSlot(5'd7, slot);
         emit(jType(5'd0, 32'd8));
         storeSlot(5'd8, slot);
      end
   endtask

   initial begin
      seed     = 59;
      memRdata = '0;
      memRbusy = 1'b0;
      memWbusy = 1'b0;
      pending  = 0;
      rdWord   = '0;
      // Fill differs at every word so a stray fetch is visible
      for (int i = 0; i < 2048; i++) begin
         mem[i] = 32'hA500_0000 | 32'(i);
      end
      mem[dataAddr[12:2]] = 32'h8F9E_A7B6;
      ptr = bootAddr;
      // x31 results base, x1 = -7, x2 = 5
      emit(uType(opLui, 5'd31, resultAddr[31:12]));
      emit(iType(opAluImm, 3'b000, 5'd1, 5'd0, -32'sd7));
      emit(iType(opAluImm, 3'b000, 5'd2, 5'd0, 32'd5));
      aluTest(7'h00, 3'b000, 0);
      aluTest(7'h20, 3'b000, 1);
      emit(iType(opAluImm, 3'b000, 5'd3, 5'd1, 32'd100));
      storeSlot(5'd3, 2);
      aluTest(7'h00, 3'b100, 3);
      aluTest(7'h00, 3'b110, 4);
      aluTest(7'h00, 3'b111, 5);
      aluTest(7'h00, 3'b010, 6);
      aluTest(7'h00, 3'b011, 7);
      aluTest(7'h00, 3'b001, 8);
      aluTest(7'h00, 3'b101, 9);
      aluTest(7'h20, 3'b101, 10);
      emit(uType(opLui, 5'd3, 20'hABCDE));
      storeSlot(5'd3, 11);
      org(auipcAt);
      emit(uType(opAuipc, 5'd3, 20'h2));
      storeSlot(5'd3, 12);
      // x4 = 0x11223344 for narrow stores
      emit(uType(opLui, 5'd4, 20'h11223));
      emit(iType(opAluImm, 3'b000, 5'd4, 5'd4, 32'h344));
      for (int k = 0; k < 4; k++) begin
         emit(sType(3'b000, 5'd4, 32'(52 + k)));
      end
      emit(sType(3'b001, 5'd4, 32'd56));
      emit(sType(3'b001, 5'd4, 32'd58));
      emit(iType(opAluImm, 3'b000, 5'd5, 5'd0, dataAddr));
      for (int k = 0; k < 4; k++) begin
         loadTest(3'b000, k, 15 + k);
      end
      for (int k = 0; k < 4; k++) begin
         loadTest(3'b100, k, 19 + k);
      end
      loadTest(3'b001, 0, 23);
      loadTest(3'b001, 2, 24);
      loadTest(3'b101, 0, 25);
      loadTest(3'b101, 2, 26);
      emit(iType(opAluImm, 3'b000, 5'd7, 5'd0, markerData));
      emit(iType(opAluImm, 3'b000, 5'd8, 5'd0, wrongPathData));
      branchTest(3'b000, 5'd1, 5'd1, 1'b1, 27);
      branchTest(3'b000, 5'd1, 5'd2, 1'b0, 28);
      branchTest(3'b001, 5'd1, 5'd2, 1'b1, 29);
      branchTest(3'b001, 5'd1, 5'd1, 1'b0, 30);
      branchTest(3'b100, 5'd1, 5'd2, 1'b1, 31);
      branchTest(3'b100, 5'd2, 5'd1, 1'b0, 32);
      branchTest(3'b101, 5'd2, 5'd1, 1'b1, 33);
      branchTest(3'b101, 5'd1, 5'd2, 1'b0, 34);
      branchTest(3'b110, 5'd2, 5'd1, 1'b1, 35);
      branchTest(3'b110, 5'd1, 5'd2, 1'b0, 36);
      branchTest(3'b111, 5'd1, 5'd2, 1'b1, 37);
      branchTest(3'b111, 5'd2, 5'd1, 1'b0, 38);
      org(jalAt);
      emit(jType(5'd9, 32'd8));
      storeSlot(5'd8, 39);
      storeSlot(5'd9, 39);
      org(jalrAt);
      emit(uType(opAuipc, 5'd10, 20'h0));
      // Odd offset, target bit 0 must be cleared
      emit(iType(opJalr, 3'b000, 5'd11, 5'd10, 32'd17));
      storeSlot(5'd8, 40);
      storeSlot(5'd8, 40);
      storeSlot(5'd11, 40);
      emit(jType(5'd0, 32'd0));
   end

   always @(posedge clk) begin
      if (!resetn) begin
         pending  <= 0;
         memRbusy <= 1'b0;
         memWbusy <= 1'b0;
      end else if (memRstrb) begin
         delay = $random(seed) & 3;
         rdWord  <= memAddr[12:2];
         pending <= delay;
         if (delay == 0) memRdata <= mem[memAddr[12:2]];
         else memRbusy <= 1'b1;
      end else if (memWstrb) begin
         delay = $random(seed) & 3;
         for (int b = 0; b < 4; b++) begin
            if (memMask[b]) mem[memAddr[12:2]][8*b +: 8] <= memWdata[8*b +: 8];
         end
         pending  <= delay;
         memWbusy <= (delay != 0);
      end else if (pending != 0) begin
         pending <= pending - 1;
         // Last busy cycle ends, read data appears with busy low
         if (pending == 1) begin
            if (memRbusy) memRdata <= mem[rdWord];
            memRbusy <= 1'b0;
            memWbusy <= 1'b0;
         end
      end
   end

endmodule

// ==== testbench/quarkTb.sv ====
/*
 * Quark core testbench
 * Runs the preloaded program and checks every result store
 */
`timescale 1ns/1ps

module quarkTb;

   localparam logic [31:0] bootAddr      = 32'h100;
   localparam logic [31:0] auipcAt       = 32'h400;
   localparam logic [31:0] jalAt         = 32'h600;
   localparam logic [31:0] jalrAt        = 32'h680;
   localparam logic [31:0] dataAddr      = 32'h700;
   localparam logic [31:0] resultAddr    = 32'h1000;
   localparam logic [31:0] markerData    = 32'h123;
   localparam logic [31:0] wrongPathData = 32'h7BD;
   localparam int          numChecks     = 45;
   // About 100 executed instructions at up to 10 cycles each, with margin
   localparam int          maxCycles     = 3000;

   logic        clk;
   logic        resetn;
   logic [31:0] memAddr, memWdata, memRdata;
   logic [3:0]  memMask;
   logic        memRstrb, memWstrb, memRbusy, memWbusy;

   logic [31:0] expAddr [numChecks];
   logic [31:0] expData [numChecks];
   logic [3:0]  expMask [numChecks];
   int          groupLast [5] = '{12, 18, 30, 42, 44};
   string       groupName [5] = '{"alu", "narrow stores", "loads", "branches", "jumps"};
   int          storeIdx;
   int          group;
   int          groupStartErrors;
   int          checks;
   int          errors;
   int          busyErrors;
   int          cycles;
   bit          firstFetchSeen;

   quarkCore #(.resetAddr(bootAddr), .addrWidth(32)) UUT (.*);

   quarkMemModel #(
      .bootAddr(bootAddr), .auipcAt(auipcAt), .jalAt(jalAt), .jalrAt(jalrAt),
      .dataAddr(dataAddr), .resultAddr(resultAddr), .markerData(markerData),
      .wrongPathData(wrongPathData)
   ) memory (.*);

   always #20 clk = ~clk;

   task automatic setExp(input int i, input int off, input logic [31:0] d,
                         input logic [3:0] m);
      expAddr[i] = resultAddr + 32'(off);
      expData[i] = d;
      expMask[i] = m;
   endtask

   task automatic noteError(input string msg);
      $display("%0t %s", $time, msg);
      errors++;
   endtask

   task automatic checkValue(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      checks++;
      assert (exp === act) else begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   // Only the lanes enabled by the mask carry store data
   task automatic checkStore(input int i);
      logic [31:0] lanes;
      lanes = {{8{expMask[i][3]}}, {8{expMask[i][2]}}, {8{expMask[i][1]}}, {8{expMask[i][0]}}};
      checkValue("memAddr", expAddr[i], memAddr);
      checkValue("memMask", 32'(expMask[i]), 32'(memMask));
      checkValue("memWdata", expData[i] & lanes, memWdata & lanes);
      if (i == groupLast[group]) begin
         $display("test %s: %0d errors", groupName[group], errors - groupStartErrors);
         groupStartErrors = errors;
         group++;
      end
   endtask

   initial begin
      // RV32I results for x1 = -7, x2 = 5
      setExp(0, 0, 32'hFFFF_FFFE, 4'hF);
      setExp(1, 4, 32'hFFFF_FFF4, 4'hF);
      setExp(2, 8, 32'h0000_005D, 4'hF);
      setExp(3, 12, 32'hFFFF_FFFC, 4'hF);
      setExp(4, 16, 32'hFFFF_FFFD, 4'hF);
      setExp(5, 20, 32'h0000_0001, 4'hF);
      setExp(6, 24, 32'h0000_0001, 4'hF);
      setExp(7, 28, 32'h0000_0000, 4'hF);
      setExp(8, 32, 32'hFFFF_FF20, 4'hF);
      setExp(9, 36, 32'h07FF_FFFF, 4'hF);
      setExp(10, 40, 32'hFFFF_FFFF, 4'hF);
      setExp(11, 44, 32'hABCD_E000, 4'hF);
      setExp(12, 48, auipcAt + 32'h2000, 4'hF);
      // Byte 0x44 and half 0x3344 land in their addressed lanes
      setExp(13, 52, 32'h0000_0044, 4'b0001);
      setExp(14, 53, 32'h0000_4400, 4'b0010);
      setExp(15, 54, 32'h0044_0000, 4'b0100);
      setExp(16, 55, 32'h4400_0000, 4'b1000);
      setExp(17, 56, 32'h0000_3344, 4'b0011);
      setExp(18, 58, 32'h3344_0000, 4'b1100);
      // Data word 0x8F9EA7B6
      setExp(19, 60, 32'hFFFF_FFB6, 4'hF);
      setExp(20, 64, 32'hFFFF_FFA7, 4'hF);
      setExp(21, 68, 32'hFFFF_FF9E, 4'hF);
      setExp(22, 72, 32'hFFFF_FF8F, 4'hF);
      setExp(23, 76, 32'h0000_00B6, 4'hF);
      setExp(24, 80, 32'h0000_00A7, 4'hF);
      setExp(25, 84, 32'h0000_009E, 4'hF);
      setExp(26, 88, 32'h0000_008F, 4'hF);
      setExp(27, 92, 32'hFFFF_A7B6, 4'hF);
      setExp(28, 96, 32'hFFFF_8F9E, 4'hF);
      setExp(29, 100, 32'h0000_A7B6, 4'hF);
      setExp(30, 104, 32'h0000_8F9E, 4'hF);
      for (int j = 0; j < 12; j++) begin
         setExp(31 + j, 108 + 4 * j, markerData, 4'hF);
      end
      // Link is the jump's own address plus four
      setExp(43, 156, jalAt + 4, 4'hF);
      setExp(44, 160, jalrAt + 8, 4'hF);
      storeIdx = 0;
      group = 0;
      groupStartErrors = 0;
      checks = 0;
      errors = 0;
      busyErrors = 0;
      cycles = 0;
      firstFetchSeen = 1'b0;
      clk = 1'b0;
      resetn = 1'b0;
      repeat (8) @(posedge clk);
      resetn <= 1'b1;
      while (storeIdx < numChecks && cycles < maxCycles) begin
         @(posedge clk);
         cycles++;
      end
      if (storeIdx < numChecks) begin
         noteError("timeout: not all result stores were seen");
      end
      $display("test back-pressure: %0d errors", busyErrors);
      $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Outputs are settled by the falling edge
   always @(negedge clk) begin
      if (!resetn) begin
         assert (!memRstrb && !memWstrb) else noteError("strobe raised during reset");
      end else begin
         assert (!((memRbusy || memWbusy) && (memRstrb || memWstrb))) else begin
            noteError("strobe raised while memory was busy");
            busyErrors++;
         end
         // Reads below the data word are instruction fetches
         if (memRstrb && memAddr < dataAddr) begin
            assert (memAddr[1:0] == 2'b00)
               else noteError("instruction fetch from a misaligned address");
         end
         if (memRstrb && !firstFetchSeen) begin
            firstFetchSeen = 1'b1;
            checkValue("memAddr", bootAddr, memAddr);
            $display("test reset: %0d errors", errors);
            groupStartErrors = errors;
         end
         if (memWstrb) begin
            if (memWdata == wrongPathData) begin
               noteError("store from the wrong side of a branch or jump reached memory");
            end else if (memAddr < resultAddr || storeIdx >= numChecks) begin
               noteError("store outside the expected result sequence");
            end else begin
               checkStore(storeIdx);
               storeIdx++;
            end
         end
      end
   end

endmodule

// ==== quark.f ====
hdl/quarkPkg.sv
hdl/quarkDecoder.sv
hdl/quarkRegFile.sv
hdl/quarkAlu.sv
hdl/quarkLoadStore.sv
hdl/quarkControl.sv
hdl/quarkCore.sv
testbench/quarkMemModel.sv
testbench/quarkTb.sv
